//--- src/isaPkg.sv
package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [15:0] instrAddr_t;  // word address, code and data alike

    typedef enum logic [5:0] {
        opNop  = 6'd0,  // all-zero word doubles as a bubble
        opAdd  = 6'd1,
        opSub  = 6'd2,
        opAnd  = 6'd3,
        opOr   = 6'd4,
        opXor  = 6'd5,
        opSlt  = 6'd6,  // signed compare
        opAddi = 6'd7,
        opLw   = 6'd8,
        opSw   = 6'd9,  // rd holds the store data register
        opBeq  = 6'd10,
        opBne  = 6'd11,
        opJmp  = 6'd12  // imm is an absolute target
    } opcode_t;

    // single instruction word format
    localparam int opMsb  = 31;
    localparam int opLsb  = 26;
    localparam int rdMsb  = 25;
    localparam int rdLsb  = 21;
    localparam int rsMsb  = 20;
    localparam int rsLsb  = 16;
    localparam int rtMsb  = 15;
    localparam int rtLsb  = 11;
    localparam int immMsb = 15;
    localparam int immLsb = 0;

    localparam int numRegs = 32;

endpackage

//--- src/pipePkg.sv
package pipePkg;

    import isaPkg::*;

    typedef enum logic [1:0] {
        fromReg = 2'd0,
        fromMem = 2'd1,  // result held in the M stage register
        fromWb  = 2'd2
    } fwdSel_t;

    // decode to execute
    typedef struct packed {
        opcode_t    op;
        regAddr_t   destReg;
        regAddr_t   srcA;
        regAddr_t   srcB;     // zero when the op reads no second register
        word_t      dataA;
        word_t      dataB;
        word_t      imm;      // already sign-extended
        instrAddr_t pc;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
    } decodeOut_t;

    // execute to memory
    typedef struct packed {
        word_t      result;   // ALU result or data address
        word_t      storeData;
        regAddr_t   destReg;
        regAddr_t   srcB;     // store data register
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
    } execOut_t;

    // memory to write-back
    typedef struct packed {
        word_t      result;
        regAddr_t   destReg;
        logic       regWrite;
        logic       memRead;
    } memOut_t;

endpackage

//--- src/fetchStage.sv
`timescale 1ns/10ps

module fetchStage import isaPkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    input  logic       nStall,
    input  logic       branchTaken,
    input  instrAddr_t branchTarget,
    output instrAddr_t pc
);

    instrAddr_t pcNext;

    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;  // redirect wins over a stall
        end else if (!nStall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + instrAddr_t'(1);
        end
    end

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    input  word_t      instr,
    input  instrAddr_t pc,
    input  logic       wbEn,
    input  regAddr_t   wbReg,
    input  word_t      wbData,
    input  regAddr_t   regAddr,
    output word_t      regData,
    output decodeOut_t decoded
);

    word_t    regFile [numRegs];
    opcode_t  op;
    regAddr_t rd;
    regAddr_t rs;
    regAddr_t rt;
    logic     wbLive;

    assign op = opcode_t'(instr[opMsb:opLsb]);
    assign rd = instr[rdMsb:rdLsb];
    assign rs = instr[rsMsb:rsLsb];
    assign rt = instr[rtMsb:rtLsb];

    assign wbLive = wbEn && (wbReg != '0);

    always_comb begin
        decoded         = '0;
        decoded.op      = op;
        decoded.destReg = rd;
        decoded.imm     = {{16{instr[immMsb]}}, instr[immMsb:immLsb]};
        decoded.pc      = pc;
        case (op)
            opAdd, opSub, opAnd, opOr, opXor, opSlt: begin
                decoded.srcA     = rs;
                decoded.srcB     = rt;
                decoded.regWrite = 1'b1;
            end
            opAddi: begin
                decoded.srcA     = rs;
                decoded.regWrite = 1'b1;
            end
            opLw: begin
                decoded.srcA     = rs;
                decoded.regWrite = 1'b1;
                decoded.memRead  = 1'b1;
            end
            opSw: begin
                decoded.srcA     = rs;
                decoded.srcB     = rd;  // data to store
                decoded.memWrite = 1'b1;
            end
            opBeq, opBne: begin
                decoded.srcA = rs;
                decoded.srcB = rd;
            end
            default: begin
                decoded.srcA = '0;  // NOP and JMP read nothing
            end
        endcase
        // write-through from W
        if (wbLive && wbReg == decoded.srcA) begin
            decoded.dataA = wbData;
        end else begin
            decoded.dataA = regFile[decoded.srcA];
        end
        if (wbLive && wbReg == decoded.srcB) begin
            decoded.dataB = wbData;
        end else begin
            decoded.dataB = regFile[decoded.srcB];
        end
    end

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbLive) begin
            regFile[wbReg] <= wbData;  // r0 never written
        end
    end

    assign regData = regFile[regAddr];  // debug port

endmodule

//--- src/executeStage.sv
`timescale 1ns/10ps

module executeStage import isaPkg::*, pipePkg::*; (
    input  decodeOut_t stage,
    input  fwdSel_t    fwdA,
    input  fwdSel_t    fwdB,
    input  word_t      memResult,
    input  word_t      wbData,
    output execOut_t   result,
    output logic       branchTaken,
    output instrAddr_t branchTarget
);

    word_t opA;
    word_t opB;
    word_t aluOut;

    always_comb begin
        case (fwdA)
            fromMem: opA = memResult;
            fromWb:  opA = wbData;
            default: opA = stage.dataA;
        endcase
        case (fwdB)
            fromMem: opB = memResult;
            fromWb:  opB = wbData;
            default: opB = stage.dataB;
        endcase
    end

    always_comb begin
        case (stage.op)
            opAdd:             aluOut = opA + opB;
            opSub:             aluOut = opA - opB;
            opAnd:             aluOut = opA & opB;
            opOr:              aluOut = opA | opB;
            opXor:             aluOut = opA ^ opB;
            opSlt:             aluOut = word_t'($signed(opA) < $signed(opB));
            opAddi, opLw, opSw: aluOut = opA + stage.imm;  // sum or address
            default:           aluOut = '0;
        endcase
    end

    always_comb begin
        result.result    = aluOut;
        result.storeData = opB;
        result.destReg   = stage.destReg;
        result.srcB      = stage.srcB;
        result.regWrite  = stage.regWrite;
        result.memRead   = stage.memRead;
        result.memWrite  = stage.memWrite;
    end

    assign branchTaken = (stage.op == opBeq && opA == opB)
                      || (stage.op == opBne && opA != opB)
                      || (stage.op == opJmp);

    assign branchTarget = (stage.op == opJmp) ? stage.imm[15:0]
                        : stage.pc + instrAddr_t'(1) + stage.imm[15:0];

    // a redirecting instruction carries no write flags from decode
    always_comb begin
        assert final (!branchTaken || !(stage.regWrite || stage.memRead || stage.memWrite))
            else $error("branch taken for non-branch instruction, opcode %0d", stage.op);
    end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import isaPkg::*, pipePkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    input  regAddr_t   decRs,
    input  regAddr_t   decRt,
    input  decodeOut_t exStage,
    input  execOut_t   memStage,
    input  memOut_t    wbStage,
    output fwdSel_t    fwdA,
    output fwdSel_t    fwdB,
    output logic       fwdStore,
    output logic       nStall
);

    logic memFwdOk;  // M result usable now
    logic wbFwdOk;
    logic loadUse;

    assign memFwdOk = memStage.regWrite && !memStage.memRead && memStage.destReg != '0;
    assign wbFwdOk  = wbStage.regWrite && wbStage.destReg != '0;

    function automatic fwdSel_t pickSource(regAddr_t src);
        if (memFwdOk && memStage.destReg == src) begin
            return fromMem;
        end else if (wbFwdOk && wbStage.destReg == src) begin
            return fromWb;
        end
        return fromReg;
    endfunction

    assign fwdA = pickSource(exStage.srcA);
    assign fwdB = pickSource(exStage.srcB);

    // SW in M catching a value written back this cycle
    assign fwdStore = memStage.memWrite && wbFwdOk && wbStage.destReg == memStage.srcB;

    assign loadUse = exStage.memRead && exStage.destReg != '0
                  && (exStage.destReg == decRs || exStage.destReg == decRt);
    assign nStall  = !loadUse;

    // bubble in E clears the hazard on the next cycle
    stallSingle: assert property (@(posedge Clock) disable iff (!nReset)
        !nStall |=> nStall)
        else $error("load-use stall lasted more than one cycle");

endmodule

//--- src/processor.sv
`timescale 1ns/10ps

module processor import isaPkg::*, pipePkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    output instrAddr_t instrAddr,
    input  word_t      instrData,
    output instrAddr_t memAddr,
    output word_t      memWriteData,
    input  word_t      memReadData,
    output logic       memRead,
    output logic       memWrite,
    input  regAddr_t   regAddr,
    output word_t      regData,
    output logic       nStall
);

    word_t      fdInstr;
    instrAddr_t fdPc;
    decodeOut_t decoded;
    decodeOut_t deReg;
    execOut_t   execResult;
    execOut_t   emReg;
    memOut_t    mwReg;
    logic       branchTaken;
    instrAddr_t branchTarget;
    fwdSel_t    fwdA;
    fwdSel_t    fwdB;
    logic       fwdStore;
    word_t      wbData;

    fetchStage fetch0 (
        .Clock       (Clock),
        .nReset      (nReset),
        .nStall      (nStall),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .pc          (instrAddr)
    );

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            fdInstr <= '0;
            fdPc    <= '0;
        end else if (branchTaken) begin
            fdInstr <= '0;  // flush to NOP
            fdPc    <= '0;
        end else if (nStall) begin
            fdInstr <= instrData;
            fdPc    <= instrAddr;
        end
    end

    decodeStage decode0 (
        .Clock  (Clock),
        .nReset (nReset),
        .instr  (fdInstr),
        .pc     (fdPc),
        .wbEn   (mwReg.regWrite),
        .wbReg  (mwReg.destReg),
        .wbData (wbData),
        .regAddr(regAddr),
        .regData(regData),
        .decoded(decoded)
    );

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            deReg <= '0;
        end else if (branchTaken || !nStall) begin
            deReg <= '0;  // bubble
        end else begin
            deReg <= decoded;
        end
    end

    executeStage exec0 (
        .stage       (deReg),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .memResult   (emReg.result),
        .wbData      (wbData),
        .result      (execResult),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            emReg <= '0;
        end else begin
            emReg <= execResult;
        end
    end

    assign memAddr      = emReg.result[15:0];
    assign memWriteData = fwdStore ? wbData : emReg.storeData;
    assign memRead      = emReg.memRead;
    assign memWrite     = emReg.memWrite;

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            mwReg <= '0;
        end else begin
            mwReg.result   <= emReg.result;
            mwReg.destReg  <= emReg.destReg;
            mwReg.regWrite <= emReg.regWrite;
            mwReg.memRead  <= emReg.memRead;
        end
    end

    assign wbData = mwReg.memRead ? memReadData : mwReg.result;  // load data arrives in W

    hazardUnit hazard0 (
        .Clock   (Clock),
        .nReset  (nReset),
        .decRs   (decoded.srcA),
        .decRt   (decoded.srcB),
        .exStage (deReg),
        .memStage(emReg),
        .wbStage (mwReg),
        .fwdA    (fwdA),
        .fwdB    (fwdB),
        .fwdStore(fwdStore),
        .nStall  (nStall)
    );

    memExclusive: assert property (@(posedge Clock) disable iff (!nReset)
        !(memRead && memWrite))
        else $error("memRead and memWrite both high");

endmodule

//--- bench/isaModel.svh
`ifndef ISAMODEL_SVH
`define ISAMODEL_SVH

word_t      progMem [256];  // also the instruction memory
int         progLen;
word_t      modelRegs [numRegs];
word_t      modelMem [256];
instrAddr_t storeAddrExp [256];
word_t      storeDataExp [256];
int         storeCount;
int         modelStalls;

function automatic word_t fillWord(logic [7:0] addr);
    return {8'hd0, addr, ~addr, addr ^ 8'h5a};
endfunction

function automatic word_t encReg(opcode_t op, regAddr_t rd, regAddr_t rs, regAddr_t rt);
    return {op, rd, rs, rt, 11'b0};
endfunction

function automatic word_t encImm(opcode_t op, regAddr_t rd, regAddr_t rs, logic [15:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic void emit(word_t w);
    progMem[8'(progLen)] = w;
    progLen++;
endfunction

function automatic void clearProgram();
    for (int i = 0; i < 256; i++) begin
        progMem[8'(i)] = '0;
    end
    progLen = 0;
endfunction

function automatic void finishProgram();
    emit(encImm(opJmp, 5'd0, 5'd0, 16'(progLen)));  // spin on itself
endfunction

function automatic void writeReg(regAddr_t rd, word_t value);
    if (rd != '0) begin
        modelRegs[rd] = value;
    end
endfunction

// executes in program order up to the final jump
function automatic void runModel();
    int       pc;
    int       steps;
    word_t    w;
    opcode_t  op;
    regAddr_t rd;
    regAddr_t rs;
    regAddr_t srcB;
    word_t    a;
    word_t    b;
    word_t    addr;
    logic     usesA;
    logic     usesB;
    logic     prevLoad;
    regAddr_t prevDest;
    for (int i = 0; i < numRegs; i++) begin
        modelRegs[5'(i)] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        modelMem[8'(i)] = fillWord(8'(i));
    end
    storeCount  = 0;
    modelStalls = 0;
    prevLoad    = 1'b0;
    prevDest    = '0;
    pc          = 0;
    steps       = 0;
    while (pc != progLen - 1 && steps < 1000) begin
        w     = progMem[8'(pc)];
        op    = opcode_t'(w[31:26]);
        rd    = w[25:21];
        rs    = w[20:16];
        usesA = !(op inside {opNop, opJmp});
        usesB = op inside {opAdd, opSub, opAnd, opOr, opXor, opSlt, opSw, opBeq, opBne};
        srcB  = (op inside {opSw, opBeq, opBne}) ? rd : w[15:11];
        a     = modelRegs[rs];
        b     = modelRegs[srcB];
        addr  = a + {{16{w[15]}}, w[15:0]};
        if (prevLoad && ((usesA && rs == prevDest) || (usesB && srcB == prevDest))) begin
            modelStalls++;
        end
        prevLoad = (op == opLw) && (rd != '0);
        prevDest = rd;
        pc++;
        case (op)
            opAdd:  writeReg(rd, a + b);
            opSub:  writeReg(rd, a - b);
            opAnd:  writeReg(rd, a & b);
            opOr:   writeReg(rd, a | b);
            opXor:  writeReg(rd, a ^ b);
            opSlt:  writeReg(rd, {31'b0, $signed(a) < $signed(b)});
            opAddi: writeReg(rd, addr);
            opLw:   writeReg(rd, modelMem[addr[7:0]]);
            opSw: begin
                modelMem[addr[7:0]]           = b;
                storeAddrExp[8'(storeCount)] = addr[15:0];
                storeDataExp[8'(storeCount)] = b;
                storeCount++;
            end
            opBeq:  if (a == b) pc += int'($signed(w[15:0]));
            opBne:  if (a != b) pc += int'($signed(w[15:0]));
            opJmp:  pc = int'(w[15:0]);
            default: ;
        endcase
        steps++;
    end
endfunction

// 64 instructions, forward branches only, then the final jump at 64
function automatic void buildRandom();
    int       pick;
    int       off;
    opcode_t  op;
    regAddr_t rd;
    regAddr_t rs;
    regAddr_t rt;
    clearProgram();
    for (int i = 0; i < 64; i++) begin
        pick = int'($urandom_range(0, 9));
        rd   = regAddr_t'($urandom_range(0, 7));
        rs   = regAddr_t'($urandom_range(0, 7));
        rt   = regAddr_t'($urandom_range(0, 7));
        if (pick < 6) begin
            op = opcode_t'(6'($urandom_range(1, 7)));
            if (op == opAddi) begin
                emit(encImm(op, rd, rs, 16'($urandom_range(0, 1023)) - 16'd512));
            end else begin
                emit(encReg(op, rd, rs, rt));
            end
        end else if (pick < 8) begin
            emit(encImm(opLw, rd, rs, 16'($urandom_range(0, 255))));
        end else if (pick == 8) begin
            emit(encImm(opSw, rd, rs, 16'($urandom_range(0, 255))));
        end else begin
            off = int'($urandom_range(0, 3));
            if (i + 1 + off > 64) begin
                off = 63 - i;
            end
            emit(encImm(opcode_t'(6'($urandom_range(10, 11))), rd, rs, 16'(off)));
        end
    end
    finishProgram();
endfunction

`endif

//--- bench/processorTb.sv
`timescale 1ns/10ps

module processorTb import isaPkg::*; ();

    localparam int cycleLimit = 4 * (2 * 64 + 20);

    logic       Clock = 1'b0;
    logic       nReset;
    instrAddr_t instrAddr;
    word_t      instrData;
    instrAddr_t memAddr;
    word_t      memWriteData;
    word_t      memReadData;
    logic       memRead;
    logic       memWrite;
    regAddr_t   regAddr;
    word_t      regData;
    logic       nStall;

    word_t      dataMem [256];
    logic       startup;
    logic       sweeping;
    logic       checkEnd;
    logic       running;
    int         cycles = 0;
    int         stallCount;
    int         storeIdx;
    int         errState = 0;
    int         errStore = 0;
    int         errReg = 0;
    int         errCount = 0;
    int         testsPassed = 0;
    int         testsFailed = 0;
    word_t      expRegData;
    instrAddr_t expStoreAddr;
    word_t      expStoreData;

    `include "isaModel.svh"

    processor dut0 (
        .Clock       (Clock),
        .nReset      (nReset),
        .instrAddr   (instrAddr),
        .instrData   (instrData),
        .memAddr     (memAddr),
        .memWriteData(memWriteData),
        .memReadData (memReadData),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .regAddr     (regAddr),
        .regData     (regData),
        .nStall      (nStall)
    );

    always #5 Clock = ~Clock;

    assign instrData    = progMem[instrAddr[7:0]];  // zero-wait fetch
    assign expRegData   = modelRegs[regAddr];
    assign expStoreAddr = storeAddrExp[8'(storeIdx)];
    assign expStoreData = storeDataExp[8'(storeIdx)];

    always @(posedge Clock) begin
        if (!nReset) begin
            for (int i = 0; i < 256; i++) begin
                dataMem[8'(i)] <= fillWord(8'(i));
            end
        end else if (memWrite) begin
            dataMem[memAddr[7:0]] <= memWriteData;
        end
        memReadData <= dataMem[memAddr[7:0]];  // valid during W
    end

    always @(posedge Clock) begin
        if (!nReset) begin
            stallCount <= 0;
            storeIdx   <= 0;
        end else begin
            if (running && !nStall) stallCount <= stallCount + 1;
            if (memWrite) storeIdx <= storeIdx + 1;
        end
    end

    always @(posedge Clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, a program never reached its final jump", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    quietStart: assert property (@(posedge Clock) startup |-> !memRead && !memWrite && nStall)
        else begin
            $display("memory strobe or stall active during reset or startup");
            errState++;
        end

    pcAtReset: assert property (@(posedge Clock) !nReset |-> instrAddr == '0)
        else begin
            $display("MISMATCH instrAddr: expected 0000, got %h", $sampled(instrAddr));
            errState++;
        end

    storeAddrOk: assert property (@(posedge Clock) nReset && memWrite |-> memAddr == expStoreAddr)
        else begin
            $display("MISMATCH memAddr: expected %h, got %h", $sampled(expStoreAddr),
                     $sampled(memAddr));
            errStore++;
        end

    storeDataOk: assert property (@(posedge Clock)
        nReset && memWrite |-> memWriteData == expStoreData)
        else begin
            $display("MISMATCH memWriteData: expected %h, got %h", $sampled(expStoreData),
                     $sampled(memWriteData));
            errStore++;
        end

    regOk: assert property (@(posedge Clock) sweeping |-> regData == expRegData)
        else begin
            $display("MISMATCH regData r%0d: expected %h, got %h", $sampled(regAddr),
                     $sampled(expRegData), $sampled(regData));
            errReg++;
        end

    stallsOk: assert property (@(posedge Clock) checkEnd |-> stallCount == modelStalls)
        else begin
            $display("MISMATCH nStall low cycles: expected %h, got %h", $sampled(modelStalls),
                     $sampled(stallCount));
            errCount++;
        end

    storesDone: assert property (@(posedge Clock) checkEnd |-> storeIdx == storeCount)
        else begin
            $display("wrong number of stores: %0d seen, %0d expected", $sampled(storeIdx),
                     $sampled(storeCount));
            errCount++;
        end

    function automatic int totalErrors();
        return errState + errStore + errReg + errCount;
    endfunction

    function automatic void buildAlu();
        clearProgram();
        emit(encImm(opAddi, 5'd1, 5'd0, 16'd5));
        emit(encImm(opAddi, 5'd2, 5'd1, -16'sd3));
        emit(encReg(opAdd, 5'd3, 5'd1, 5'd2));
        emit(encReg(opSub, 5'd4, 5'd3, 5'd1));
        emit(encReg(opAnd, 5'd5, 5'd4, 5'd3));
        emit(encReg(opOr, 5'd6, 5'd5, 5'd1));
        emit(encReg(opXor, 5'd7, 5'd6, 5'd3));
        emit(encReg(opSlt, 5'd8, 5'd4, 5'd7));
        emit(encImm(opAddi, 5'd0, 5'd1, 16'd9));  // r0 stays zero
        emit(encReg(opAdd, 5'd10, 5'd0, 5'd1));
        emit(encImm(opAddi, 5'd11, 5'd10, -16'sd100));
        emit(encReg(opSlt, 5'd12, 5'd11, 5'd0));
        finishProgram();
    endfunction

    function automatic void buildLoadStore();
        clearProgram();
        emit(encImm(opAddi, 5'd1, 5'd0, 16'd10));
        emit(encImm(opLw, 5'd2, 5'd1, 16'd3));
        emit(encReg(opAdd, 5'd3, 5'd2, 5'd1));     // load-use
        emit(encImm(opAddi, 5'd4, 5'd3, 16'd1));
        emit(encImm(opSw, 5'd4, 5'd0, 16'd20));     // data from previous op
        emit(encImm(opLw, 5'd5, 5'd0, 16'd20));
        emit(encImm(opSw, 5'd5, 5'd1, 16'd21));     // load-use on store data
        emit(encImm(opLw, 5'd6, 5'd1, 16'd0));
        emit(encImm(opAddi, 5'd7, 5'd0, 16'd2));
        emit(encReg(opAdd, 5'd8, 5'd6, 5'd7));
        emit(encImm(opSw, 5'd8, 5'd1, -16'sd1));
        emit(encImm(opLw, 5'd0, 5'd0, 16'd5));
        emit(encReg(opAdd, 5'd9, 5'd0, 5'd1));
        finishProgram();
    endfunction

    function automatic void buildBranch();
        clearProgram();
        emit(encImm(opAddi, 5'd1, 5'd0, 16'd7));
        emit(encImm(opAddi, 5'd2, 5'd0, 16'd7));
        emit(encImm(opBeq, 5'd2, 5'd1, 16'd2));    // taken
        emit(encImm(opAddi, 5'd3, 5'd0, 16'd99));
        emit(encImm(opAddi, 5'd4, 5'd0, 16'd99));
        emit(encImm(opBne, 5'd2, 5'd1, 16'd2));    // not taken
        emit(encImm(opAddi, 5'd5, 5'd0, 16'd11));
        emit(encImm(opBne, 5'd5, 5'd1, 16'd1));    // taken
        emit(encImm(opAddi, 5'd6, 5'd0, 16'd99));
        emit(encImm(opBeq, 5'd5, 5'd1, 16'd1));    // not taken
        emit(encImm(opAddi, 5'd7, 5'd5, 16'd1));
        emit(encImm(opJmp, 5'd0, 5'd0, 16'd14));
        emit(encImm(opAddi, 5'd8, 5'd0, 16'd99));
        emit(encImm(opAddi, 5'd9, 5'd0, 16'd99));
        emit(encReg(opAdd, 5'd10, 5'd7, 5'd5));
        finishProgram();
    endfunction

    task automatic runProgram(input string name);
        int errsBefore;
        int visits;
        errsBefore = totalErrors();
        runModel();
        nReset  = 1'b0;
        startup = 1'b1;
        repeat (4) @(negedge Clock);
        nReset  = 1'b1;
        running = 1'b1;
        repeat (2) @(negedge Clock);  // bubbles only, whatever the program
        startup = 1'b0;
        visits  = 0;
        while (visits < 3) begin  // third fetch of the final jump means drained
            @(negedge Clock);
            if (instrAddr == instrAddr_t'(progLen - 1)) visits++;
        end
        repeat (2) @(negedge Clock);
        running  = 1'b0;
        sweeping = 1'b1;
        for (int r = 0; r < numRegs; r++) begin
            regAddr = regAddr_t'(r);
            @(negedge Clock);
        end
        sweeping = 1'b0;
        checkEnd = 1'b1;
        @(negedge Clock);
        checkEnd = 1'b0;
        @(negedge Clock);
        if (totalErrors() == errsBefore) begin
            testsPassed++;
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, totalErrors() - errsBefore);
        end
    endtask

    initial begin
        void'($urandom(32'hf703));
        nReset   = 1'b0;
        regAddr  = '0;
        startup  = 1'b1;
        sweeping = 1'b0;
        checkEnd = 1'b0;
        running  = 1'b0;
        buildAlu();
        runProgram("alu");
        buildLoadStore();
        runProgram("loadstore");
        buildBranch();
        runProgram("branch");
        buildRandom();
        runProgram("random");
        $display("tests passed %0d, tests failed %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+bench
src/isaPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/hazardUnit.sv
src/processor.sv
bench/processorTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module processorTb -Mdir obj_dir

out=$(./obj_dir/VprocessorTb)
echo "$out"

echo "$out" | grep -q "Verification passed"
